//--- src/keypad_pkg.sv
package keypad_pkg;

    // active low keypad lines, one bit per row or column
    typedef logic [3:0] lines_t;

    // {rows, cols} as sampled at READ
    typedef logic [7:0] coord_t;

    // row * 4 + column
    typedef logic [3:0] key_code_t;

    typedef enum logic [7:0] {
        IDLE           = 8'b0000_0001,
        SETTLE_PRESS   = 8'b0000_0010,
        COL1           = 8'b0000_0100,
        COL2           = 8'b0000_1000,
        COL3           = 8'b0001_0000,
        COL4           = 8'b0010_0000,
        READ           = 8'b0100_0000,
        SETTLE_RELEASE = 8'b1000_0000
    } scan_state_t;

    localparam int DEFAULT_DEBOUNCE = 2_000_000;  // 20 ms at 100 MHz
    localparam int DEFAULT_STEP_DIV = 4;

    localparam lines_t LINES_IDLE    = 4'b1111;  // nothing pulled low
    localparam lines_t LINES_ALL_LOW = 4'b0000;  // every column driven

    // one column low at a time, COL1 takes the top bit
    localparam lines_t COL1_DRIVE = 4'b0111;
    localparam lines_t COL2_DRIVE = 4'b1011;
    localparam lines_t COL3_DRIVE = 4'b1101;
    localparam lines_t COL4_DRIVE = 4'b1110;

endpackage

//--- src/keypad_scanner.sv
`timescale 1ns/1ps

module keypad_scanner #(
    parameter int DEBOUNCE_PERIOD = keypad_pkg::DEFAULT_DEBOUNCE,
    parameter int STEP_DIV        = keypad_pkg::DEFAULT_STEP_DIV
) (
    input  logic               clk,
    input  logic               rst_n,
    input  keypad_pkg::lines_t row_in,
    output keypad_pkg::lines_t col_out,
    output keypad_pkg::coord_t coord,
    output logic               coord_valid
);
    import keypad_pkg::*;

    localparam int STEP_W = (STEP_DIV > 0) ? $clog2(STEP_DIV + 1) : 1;
    localparam int DB_W   = (DEBOUNCE_PERIOD > 0) ? $clog2(DEBOUNCE_PERIOD + 1) : 1;

    localparam logic [STEP_W-1:0] STEP_LAST = STEP_W'(STEP_DIV);
    localparam logic [DB_W-1:0]   DB_LAST   = DB_W'(DEBOUNCE_PERIOD);

    logic [STEP_W-1:0] step_cnt;
    logic              step;
    logic [DB_W-1:0]   db_cnt;
    logic              settle_level;
    logic              settle_done;
    logic              pressed;
    scan_state_t       state;
    scan_state_t       next_state;
    lines_t            row_val;
    lines_t            col_val;
    logic              emit;

    // prescaler, one step every STEP_DIV+1 clocks
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            step_cnt <= '0;
        end else if (step) begin
            step_cnt <= '0;
        end else begin
            step_cnt <= step_cnt + 1'b1;
        end
    end

    assign step    = (step_cnt == STEP_LAST);
    assign pressed = (row_in != LINES_IDLE);

    // level the debounce counter waits for in each settle state
    always_comb begin
        case (state)
            SETTLE_PRESS:   settle_level = pressed;
            SETTLE_RELEASE: settle_level = !pressed;
            default:        settle_level = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n || !settle_level) begin
            db_cnt <= '0;   // restart on any bounce
        end else if (!settle_done) begin
            db_cnt <= db_cnt + 1'b1;
        end
    end

    assign settle_done = (db_cnt == DB_LAST);

    always_comb begin
        next_state = IDLE;
        case (state)
            IDLE:
                next_state = pressed ? SETTLE_PRESS : IDLE;
            SETTLE_PRESS: begin
                if (!pressed) begin
                    next_state = IDLE;   // too short, forget it
                end else if (settle_done) begin
                    next_state = COL1;
                end else begin
                    next_state = SETTLE_PRESS;
                end
            end
            COL1:
                next_state = pressed ? READ : COL2;
            COL2:
                next_state = pressed ? READ : COL3;
            COL3:
                next_state = pressed ? READ : COL4;
            COL4:
                next_state = pressed ? READ : IDLE;
            READ:
                next_state = pressed ? SETTLE_RELEASE : IDLE;
            SETTLE_RELEASE:
                next_state = settle_done ? IDLE : SETTLE_RELEASE;
            default:
                next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= IDLE;
        end else if (step) begin
            state <= next_state;
        end
    end

    // column drive follows the state being entered
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            col_out <= LINES_ALL_LOW;
        end else if (step) begin
            case (next_state)
                COL1:    col_out <= COL1_DRIVE;
                COL2:    col_out <= COL2_DRIVE;
                COL3:    col_out <= COL3_DRIVE;
                COL4:    col_out <= COL4_DRIVE;
                READ:    col_out <= col_out;   // keep the column that hit
                default: col_out <= LINES_ALL_LOW;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (step && next_state == READ) begin
            row_val <= row_in;
            col_val <= col_out;
        end
    end

    assign emit = step && (state == SETTLE_RELEASE) && (next_state == IDLE);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            coord_valid <= 1'b0;
        end else begin
            coord_valid <= emit;
        end
    end

    always_ff @(posedge clk) begin
        if (emit) begin
            coord <= {row_val, col_val};
        end
    end

    a_state_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot(state));

    a_valid_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        coord_valid |=> !coord_valid);

endmodule

//--- src/key_decoder.sv
`timescale 1ns/1ps

module key_decoder (
    input  logic                  clk,
    input  logic                  rst_n,
    input  keypad_pkg::coord_t    coord,
    input  logic                  coord_valid,
    output keypad_pkg::key_code_t code,
    output logic                  code_valid,
    output logic                  key_error
);
    import keypad_pkg::*;

    lines_t rows;
    lines_t cols;
    logic   legal;

    // exactly one line low
    function automatic logic one_cold(input lines_t l);
        return $countones(~l) == 1;
    endfunction

    // position of the low line, top bit is index 0
    function automatic logic [1:0] cold_index(input lines_t l);
        case (l)
            4'b0111: return 2'd0;
            4'b1011: return 2'd1;
            4'b1101: return 2'd2;
            default: return 2'd3;
        endcase
    endfunction

    assign rows  = coord[7:4];
    assign cols  = coord[3:0];
    assign legal = one_cold(rows) && one_cold(cols);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            code_valid <= 1'b0;
            key_error  <= 1'b0;
        end else begin
            code_valid <= coord_valid && legal;
            key_error  <= coord_valid && !legal;   // ghosting or bad sample
        end
    end

    always_ff @(posedge clk) begin
        if (coord_valid && legal) begin
            code <= {cold_index(rows), cold_index(cols)};
        end
    end

    // every result answers a coordinate from the clock before, one way only
    a_one_result: assert property (@(posedge clk) disable iff (!rst_n)
        (code_valid || key_error) |-> (code_valid != key_error) && $past(coord_valid));

endmodule

//--- src/key_fifo.sv
`timescale 1ns/1ps

module key_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  push,
    input  keypad_pkg::key_code_t push_code,
    input  logic                  pop,
    output keypad_pkg::key_code_t head,
    output logic                  not_empty,
    output logic                  dropped
);
    import keypad_pkg::*;

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(FIFO_DEPTH);

    key_code_t        mem [FIFO_DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             do_push;
    logic             do_pop;

    assign full      = (count == CNT_FULL);
    assign not_empty = (count != '0);
    assign do_pop    = pop && not_empty;
    assign do_push   = push && (!full || do_pop);   // a pop frees the slot this clock
    assign head      = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_ptr  <= '0;
            wr_ptr  <= '0;
            count   <= '0;
            dropped <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;   // wraps, depth is a power of two
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            dropped <= push && !do_push;
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_code;
        end
    end

    a_count_bound: assert property (@(posedge clk) disable iff (!rst_n)
        count <= CNT_FULL);

endmodule

//--- src/keypad_top.sv
`timescale 1ns/1ps

module keypad_top #(
    parameter int DEBOUNCE_PERIOD = keypad_pkg::DEFAULT_DEBOUNCE,
    parameter int STEP_DIV        = keypad_pkg::DEFAULT_STEP_DIV,
    parameter int FIFO_DEPTH      = 4
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  keypad_pkg::lines_t    row_in,
    output keypad_pkg::lines_t    col_out,
    input  logic                  key_pop,
    output keypad_pkg::key_code_t key_code,
    output logic                  key_avail,
    output logic                  key_error,
    output logic                  key_dropped
);
    import keypad_pkg::*;

    coord_t    coord;
    logic      coord_valid;
    key_code_t code;
    logic      code_valid;

    keypad_scanner #(
        .DEBOUNCE_PERIOD (DEBOUNCE_PERIOD),
        .STEP_DIV        (STEP_DIV)
    ) scanner_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .row_in      (row_in),
        .col_out     (col_out),
        .coord       (coord),
        .coord_valid (coord_valid)
    );

    key_decoder decoder_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .coord       (coord),
        .coord_valid (coord_valid),
        .code        (code),
        .code_valid  (code_valid),
        .key_error   (key_error)
    );

    // no back-pressure to the scanner, overflow drops the newest code
    key_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) fifo_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (code_valid),
        .push_code (code),
        .pop       (key_pop),
        .head      (key_code),
        .not_empty (key_avail),
        .dropped   (key_dropped)
    );

endmodule

//--- tests/keypad_model.sv
`timescale 1ns/1ps

module keypad_model (
    input  logic [15:0]        pressed,   // bit r*4+c is the key at row r, column c
    input  keypad_pkg::lines_t col_out,
    output keypad_pkg::lines_t row_in
);
    import keypad_pkg::*;

    // a held key ties its row to its column, so the row follows a low column
    always_comb begin
        row_in = LINES_IDLE;
        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 4; c++) begin
                if (pressed[r * 4 + c] && !col_out[3 - c]) begin
                    row_in[3 - r] = 1'b0;   // index 0 sits on the top bit
                end
            end
        end
    end

endmodule

//--- tests/keypad_tb.sv
`timescale 1ns/1ps

module keypad_tb;
    import keypad_pkg::*;

    localparam int FIFO_DEPTH     = 4;
    localparam int DEBOUNCE       = 20;
    localparam int PRESS_CYCLES   = 80;   // debounce plus a full column sweep
    localparam int SHORT_CYCLES   = DEBOUNCE - 1;   // long enough for a sweep, not for the settle
    localparam int WAIT_LIMIT     = 100;
    localparam int NUM_PRESSES    = 16 + 2 + 1 + FIFO_DEPTH + 2;
    localparam int TIMEOUT_CYCLES = NUM_PRESSES * (PRESS_CYCLES + WAIT_LIMIT) * 2 + 500;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        key_pop;
    logic [15:0] pressed;
    logic [15:0] mask;
    lines_t      row_in;
    lines_t      col_out;
    key_code_t   key_code;
    key_code_t   exp_code;
    key_code_t   exp_list [FIFO_DEPTH];
    logic        key_avail;
    logic        key_error;
    logic        key_dropped;
    logic        got_err;
    logic        got_drop;
    logic [31:0] rnd;
    integer      seed = 32'h18dd3ad9;
    int          scan_count;
    int          err_count;
    int          drop_count;
    int          cycles;
    int          stim_fails;
    int          cmp_fails = 0;
    int          fails_before;
    int          tests_passed;
    int          tests_failed;
    int          outcome;

    keypad_top #(
        .DEBOUNCE_PERIOD (DEBOUNCE),
        .STEP_DIV        (4),
        .FIFO_DEPTH      (FIFO_DEPTH)
    ) dut_i (.*);

    keypad_model model_i (.*);

    always #10 clk = ~clk;

    // code of the first column that answers the sweep or -1 when it shows several rows
    function automatic int expected_outcome(input logic [15:0] keys);
        int hits;
        int row;
        for (int c = 0; c < 4; c++) begin
            hits = 0;
            row = 0;
            for (int r = 0; r < 4; r++) begin
                if (keys[r * 4 + c]) begin
                    hits++;
                    row = r;
                end
            end
            if (hits != 0) begin
                return (hits == 1) ? row * 4 + c : -1;
            end
        end
        return -1;
    endfunction

    task automatic check_code(input string name, input key_code_t got, input key_code_t exp);
        if (got !== exp) begin
            $display("[FAIL] %0t %s got %0d expected %0d", $time, name, got, exp);
            cmp_fails++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] %0t %s got %b expected %b", $time, name, got, exp);
            stim_fails++;
        end
    endtask

    task automatic check_lines(input string name, input lines_t got, input lines_t exp);
        if (got !== exp) begin
            $display("[FAIL] %0t %s got %b expected %b", $time, name, got, exp);
            stim_fails++;
        end
    endtask

    // head of the queue checked on every real pop
    always @(negedge clk) begin
        if (rst_n && key_pop && key_avail) begin
            check_code("key_code", key_code, exp_code);
        end
        scan_count <= scan_count + int'(dut_i.coord_valid);
        err_count  <= err_count + int'(key_error);
        drop_count <= drop_count + int'(key_dropped);
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("run stopped after %0d cycles, the tests did not finish", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    // hold a key set, let go, then wait for the scanner to report the coordinate
    task automatic run_press(input logic [15:0] keys, input int hold, input logic expect_scan);
        int   scans_before;
        int   errs_before;
        int   drops_before;
        logic scanned;
        scans_before = scan_count;
        errs_before = err_count;
        drops_before = drop_count;
        scanned = 1'b0;
        @(posedge clk);
        pressed <= keys;
        repeat (hold) @(posedge clk);
        pressed <= '0;
        for (int n = 0; n < WAIT_LIMIT && !scanned; n++) begin
            @(posedge clk);
            scanned = (scan_count != scans_before);
        end
        repeat (3) @(posedge clk);   // decoder and queue stages
        if (scanned != expect_scan) begin
            $display("key mask %h: scan result %s", keys, scanned ? "not expected" : "missing");
            stim_fails++;
        end
        got_err = (err_count != errs_before);
        got_drop = (drop_count != drops_before);
    endtask

    task automatic pop_key(input key_code_t expected, input logic expect_avail);
        exp_code = expected;
        @(negedge clk);
        check_flag("key_avail", key_avail, expect_avail);
        @(posedge clk);
        key_pop <= 1'b1;
        @(posedge clk);
        key_pop <= 1'b0;
    endtask

    task automatic finish_test(input string name);
        if (stim_fails + cmp_fails == fails_before) begin
            tests_passed++;
            $display("%s: pass", name);
        end else begin
            tests_failed++;
            $display("%s: fail", name);
        end
        fails_before = stim_fails + cmp_fails;
    endtask

    initial begin
        rst_n <= 1'b0;
        key_pop <= 1'b0;
        pressed <= '0;
        exp_code = '0;
        stim_fails = 0;
        fails_before = 0;
        tests_passed = 0;
        tests_failed = 0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;

        @(negedge clk);
        check_lines("col_out", col_out, LINES_ALL_LOW);
        check_flag("key_avail", key_avail, 1'b0);
        finish_test("reset state");

        for (int k = 0; k < 16; k++) begin
            mask = 16'b1 << k;
            outcome = expected_outcome(mask);
            run_press(mask, PRESS_CYCLES, 1'b1);
            check_flag("key_error", got_err, 1'b0);
            pop_key(key_code_t'(outcome), 1'b1);
        end
        finish_test("single keys");

        // same row, then same column
        for (int i = 0; i < 2; i++) begin
            mask = (i == 0) ? 16'h0a00 : 16'h0022;
            outcome = expected_outcome(mask);
            run_press(mask, PRESS_CYCLES, 1'b1);
            check_flag("key_error", got_err, outcome < 0);
            if (outcome >= 0) begin
                pop_key(key_code_t'(outcome), 1'b1);
            end else begin
                check_flag("key_avail", key_avail, 1'b0);
            end
        end
        finish_test("two keys");

        // column 0 key so only the debounce holds it back
        run_press(16'h0010, SHORT_CYCLES, 1'b0);
        check_flag("key_error", got_err, 1'b0);
        check_flag("key_avail", key_avail, 1'b0);
        finish_test("short press");

        for (int i = 0; i < FIFO_DEPTH + 2; i++) begin
            rnd = $random(seed);
            mask = 16'b1 << rnd[3:0];
            outcome = expected_outcome(mask);
            if (i < FIFO_DEPTH) begin
                exp_list[i] = key_code_t'(outcome);
            end
            run_press(mask, PRESS_CYCLES, 1'b1);
            check_flag("key_dropped", got_drop, i >= FIFO_DEPTH);
        end
        for (int i = 0; i < FIFO_DEPTH; i++) begin
            pop_key(exp_list[i], 1'b1);
        end
        finish_test("queue overflow");

        pop_key('0, 1'b0);
        @(negedge clk);
        check_flag("key_avail", key_avail, 1'b0);
        check_flag("key_dropped", key_dropped, 1'b0);
        finish_test("pop when empty");

        $display("tests passed %0d, failed %0d, failed checks %0d",
                 tests_passed, tests_failed, stim_fails + cmp_fails);
        if (tests_failed == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- tb.f
src/keypad_pkg.sv
src/keypad_scanner.sv
src/key_decoder.sv
src/key_fifo.sv
src/keypad_top.sv
tests/keypad_model.sv
tests/keypad_tb.sv

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module keypad_tb -f tb.f -o keypad_sim \
    && ./obj_dir/keypad_sim | tee /dev/stderr | grep -q "^TEST OK$" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
